//--- rtl/ooo_pkg.sv
package ooo_pkg;

    localparam int XLEN      = 32;
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;
    localparam int AREG_W    = 5;
    localparam int PREG_W    = 6;
    localparam int ROB_IDX_W = 4;

    typedef logic [XLEN-1:0]      data_t;
    typedef logic [AREG_W-1:0]    areg_t;
    typedef logic [PREG_W-1:0]    preg_t;
    typedef logic [15:0]          imm_t;
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLT = 3'd5,
        OP_SLL = 3'd6,
        OP_LI  = 3'd7
    } alu_op_e;

    // micro-op as it arrives from the front end
    typedef struct packed {
        alu_op_e op;
        areg_t   rd;
        areg_t   rs1;
        areg_t   rs2;
        imm_t    imm;
    } uop_t;

    typedef struct packed {
        alu_op_e  op;
        preg_t    prd;
        preg_t    ps1;
        preg_t    ps2;
        imm_t     imm;
        rob_idx_t rob_idx;
    } renamed_uop_t;

    typedef struct packed {
        logic     valid;
        preg_t    prd;
        rob_idx_t rob_idx;
        data_t    value;
    } wb_t;

    typedef struct packed {
        areg_t rd;
        data_t value;
    } retire_t;

endpackage

//--- rtl/rename_unit.sv
`timescale 1ns/10ps

module rename_unit
    import ooo_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         in_req_i,
    input  uop_t         in_uop_i,
    output logic         in_ack_o,
    input  logic         iq_ready_i,
    input  logic         rob_ready_i,
    input  rob_idx_t     rob_tail_i,
    input  logic         free_valid_i,
    input  preg_t        free_prd_i,
    output logic         disp_valid_o,
    output renamed_uop_t disp_uop_o,
    output areg_t        disp_rd_o,
    output preg_t        disp_old_prd_o
);

    localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;
    localparam int FL_W       = $clog2(FREE_DEPTH);

    preg_t           map_table [ARCH_REGS];
    preg_t           free_list [FREE_DEPTH];
    logic [FL_W-1:0] free_head;
    logic [FL_W-1:0] free_tail;
    logic [FL_W:0]   free_count;
    logic            ack_q;
    logic            accept;

    // take a new micro-op only when every downstream structure has room
    assign accept = in_req_i && !ack_q && (free_count != '0) && iq_ready_i && rob_ready_i;

    assign in_ack_o       = ack_q;
    assign disp_valid_o   = accept;
    assign disp_rd_o      = in_uop_i.rd;
    assign disp_old_prd_o = map_table[in_uop_i.rd];

    // sources read the old mapping, so rd == rs1 works
    assign disp_uop_o = '{
        op:      in_uop_i.op,
        prd:     free_list[free_head],
        ps1:     map_table[in_uop_i.rs1],
        ps2:     map_table[in_uop_i.rs2],
        imm:     in_uop_i.imm,
        rob_idx: rob_tail_i
    };

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q      <= 1'b0;
            free_head  <= '0;
            free_tail  <= '0;
            free_count <= (FL_W + 1)'(FREE_DEPTH);
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_table[i] <= preg_t'(i);
            end
            for (int i = 0; i < FREE_DEPTH; i++) begin
                free_list[i] <= preg_t'(ARCH_REGS + i);
            end
        end else begin
            if (accept) begin
                ack_q <= 1'b1;
            end else if (!in_req_i) begin
                ack_q <= 1'b0;
            end

            if (accept) begin
                map_table[in_uop_i.rd] <= free_list[free_head];
                free_head              <= free_head + 1'b1;
            end

            // registers coming back from retirement
            if (free_valid_i) begin
                free_list[free_tail] <= free_prd_i;
                free_tail            <= free_tail + 1'b1;
            end

            case ({accept, free_valid_i})
                2'b10:   free_count <= free_count - 1'b1;
                2'b01:   free_count <= free_count + 1'b1;
                default: free_count <= free_count;
            endcase
        end
    end

endmodule

//--- rtl/busy_table.sv
`timescale 1ns/10ps

module busy_table
    import ooo_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  set_valid_i,
    input  preg_t set_prd_i,
    input  wb_t   wb_i,
    input  preg_t query_a_i,
    input  preg_t query_b_i,
    output logic  ready_a_o,
    output logic  ready_b_o
);

    logic [PHYS_REGS-1:0] busy_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q <= '0;
        end else begin
            if (wb_i.valid) begin
                busy_q[wb_i.prd] <= 1'b0;
            end
            // a freshly popped register is never the one being written back
            if (set_valid_i) begin
                busy_q[set_prd_i] <= 1'b1;
            end
        end
    end

    assign ready_a_o = !busy_q[query_a_i];
    assign ready_b_o = !busy_q[query_b_i];

endmodule

//--- rtl/issue_queue.sv
`timescale 1ns/10ps

module issue_queue
    import ooo_pkg::*;
#(
    parameter int IQ_DEPTH = 8
) (
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         disp_valid_i,
    input  renamed_uop_t disp_uop_i,
    input  logic         src_a_ready_i,
    input  logic         src_b_ready_i,
    input  wb_t          wb_i,
    output logic         iq_ready_o,
    output logic         issue_valid_o,
    output renamed_uop_t issue_uop_o
);

    localparam int IDX_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;

    renamed_uop_t        entry_q [IQ_DEPTH];
    logic [IQ_DEPTH-1:0] valid_q;
    logic [IQ_DEPTH-1:0] rdy_a_q;
    logic [IQ_DEPTH-1:0] rdy_b_q;
    logic [IDX_W-1:0]    sel_idx;
    logic [IDX_W-1:0]    free_idx;
    logic                sel_found;
    logic                free_found;
    logic                uses_src;
    logic                init_rdy_a;
    logic                init_rdy_b;

    // pick lowest ready entry and lowest empty slot
    always_comb begin
        sel_found  = 1'b0;
        sel_idx    = '0;
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (valid_q[i] && rdy_a_q[i] && rdy_b_q[i]) begin
                sel_found = 1'b1;
                sel_idx   = IDX_W'(i);
            end
            if (!valid_q[i]) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
        end
    end

    // LI reads no registers
    assign uses_src   = (disp_uop_i.op != OP_LI);
    assign init_rdy_a = !uses_src || src_a_ready_i || (wb_i.valid && wb_i.prd == disp_uop_i.ps1);
    assign init_rdy_b = !uses_src || src_b_ready_i || (wb_i.valid && wb_i.prd == disp_uop_i.ps2);

    assign iq_ready_o    = free_found;
    assign issue_valid_o = sel_found;
    assign issue_uop_o   = entry_q[sel_idx];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            rdy_a_q <= '0;
            rdy_b_q <= '0;
        end else begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                if (valid_q[i] && wb_i.valid && entry_q[i].ps1 == wb_i.prd) begin
                    rdy_a_q[i] <= 1'b1;
                end
                if (valid_q[i] && wb_i.valid && entry_q[i].ps2 == wb_i.prd) begin
                    rdy_b_q[i] <= 1'b1;
                end
            end
            if (sel_found) begin
                valid_q[sel_idx] <= 1'b0;
            end
            // free slot is never the issuing one
            if (disp_valid_i) begin
                valid_q[free_idx] <= 1'b1;
                rdy_a_q[free_idx] <= init_rdy_a;
                rdy_b_q[free_idx] <= init_rdy_b;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (disp_valid_i) begin
            entry_q[free_idx] <= disp_uop_i;
        end
    end

endmodule

//--- rtl/phys_regfile.sv
`timescale 1ns/10ps

module phys_regfile
    import ooo_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n_i,
    input  preg_t raddr_a_i,
    input  preg_t raddr_b_i,
    output data_t rdata_a_o,
    output data_t rdata_b_o,
    input  wb_t   wb_i
);

    data_t regs_q [PHYS_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.valid) begin
            regs_q[wb_i.prd] <= wb_i.value;
        end
    end

    // no bypass needed, consumers issue after the write edge
    assign rdata_a_o = regs_q[raddr_a_i];
    assign rdata_b_o = regs_q[raddr_b_i];

endmodule

//--- rtl/alu_pipe.sv
`timescale 1ns/10ps

module alu_pipe
    import ooo_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         issue_valid_i,
    input  renamed_uop_t issue_uop_i,
    input  data_t        rdata_a_i,
    input  data_t        rdata_b_i,
    output wb_t          wb_o
);

    data_t    result;
    logic     wb_valid_q;
    preg_t    wb_prd_q;
    rob_idx_t wb_rob_q;
    data_t    wb_value_q;

    always_comb begin
        case (issue_uop_i.op)
            OP_ADD:  result = rdata_a_i + rdata_b_i;
            OP_SUB:  result = rdata_a_i - rdata_b_i;
            OP_AND:  result = rdata_a_i & rdata_b_i;
            OP_OR:   result = rdata_a_i | rdata_b_i;
            OP_XOR:  result = rdata_a_i ^ rdata_b_i;
            OP_SLT:  result = ($signed(rdata_a_i) < $signed(rdata_b_i)) ? 32'd1 : 32'd0;
            OP_SLL:  result = rdata_a_i << rdata_b_i[4:0];
            OP_LI:   result = {{16{issue_uop_i.imm[15]}}, issue_uop_i.imm};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= issue_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid_i) begin
            wb_prd_q   <= issue_uop_i.prd;
            wb_rob_q   <= issue_uop_i.rob_idx;
            wb_value_q <= result;
        end
    end

    assign wb_o = '{valid: wb_valid_q, prd: wb_prd_q, rob_idx: wb_rob_q, value: wb_value_q};

endmodule

//--- rtl/reorder_buffer.sv
`timescale 1ns/10ps

module reorder_buffer
    import ooo_pkg::*;
#(
    parameter int ROB_DEPTH = 16
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     disp_valid_i,
    input  areg_t    disp_rd_i,
    input  preg_t    disp_old_prd_i,
    output logic     rob_ready_o,
    output rob_idx_t rob_tail_o,
    input  wb_t      wb_i,
    output logic     retire_req_o,
    output retire_t  retire_o,
    input  logic     retire_ack_i,
    output logic     free_valid_o,
    output preg_t    free_prd_o
);

    localparam int CNT_W = ROB_IDX_W + 1;

    areg_t                rd_q      [ROB_DEPTH];
    preg_t                old_prd_q [ROB_DEPTH];
    data_t                value_q   [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;
    rob_idx_t             head_q;
    rob_idx_t             tail_q;
    logic [CNT_W-1:0]     count_q;
    logic                 req_q;
    logic                 retire_fire;

    // wrap also works for depths below 2**ROB_IDX_W
    function automatic rob_idx_t next_idx(input rob_idx_t idx);
        if (idx == rob_idx_t'(ROB_DEPTH - 1)) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    assign retire_fire  = req_q && retire_ack_i;
    assign rob_ready_o  = (count_q != CNT_W'(ROB_DEPTH));
    assign rob_tail_o   = tail_q;
    assign retire_req_o = req_q;
    assign retire_o     = '{rd: rd_q[head_q], value: value_q[head_q]};
    assign free_valid_o = retire_fire;
    assign free_prd_o   = old_prd_q[head_q];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            req_q   <= 1'b0;
            done_q  <= '0;
        end else begin
            if (wb_i.valid) begin
                done_q[wb_i.rob_idx] <= 1'b1;
            end
            if (disp_valid_i) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= next_idx(tail_q);
            end
            // wait for ack low before offering the next head
            if (retire_fire) begin
                req_q  <= 1'b0;
                head_q <= next_idx(head_q);
            end else if (!req_q && !retire_ack_i && count_q != '0 && done_q[head_q]) begin
                req_q <= 1'b1;
            end
            case ({disp_valid_i, retire_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (disp_valid_i) begin
            rd_q[tail_q]      <= disp_rd_i;
            old_prd_q[tail_q] <= disp_old_prd_i;
        end
        if (wb_i.valid) begin
            value_q[wb_i.rob_idx] <= wb_i.value;
        end
    end

endmodule

//--- rtl/ooo_core.sv
`timescale 1ns/10ps

module ooo_core
    import ooo_pkg::*;
#(
    parameter int IQ_DEPTH  = 8,
    parameter int ROB_DEPTH = 16
) (
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    in_req_i,
    input  uop_t    in_uop_i,
    output logic    in_ack_o,
    output logic    retire_req_o,
    output retire_t retire_o,
    input  logic    retire_ack_i
);

    logic         disp_valid;
    renamed_uop_t disp_uop;
    areg_t        disp_rd;
    preg_t        disp_old_prd;
    logic         iq_ready;
    logic         rob_ready;
    rob_idx_t     rob_tail;
    logic         free_valid;
    preg_t        free_prd;
    logic         src_a_ready;
    logic         src_b_ready;
    logic         issue_valid;
    renamed_uop_t issue_uop;
    data_t        rdata_a;
    data_t        rdata_b;
    wb_t          wb;

    rename_unit u_rename (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .in_req_i       (in_req_i),
        .in_uop_i       (in_uop_i),
        .in_ack_o       (in_ack_o),
        .iq_ready_i     (iq_ready),
        .rob_ready_i    (rob_ready),
        .rob_tail_i     (rob_tail),
        .free_valid_i   (free_valid),
        .free_prd_i     (free_prd),
        .disp_valid_o   (disp_valid),
        .disp_uop_o     (disp_uop),
        .disp_rd_o      (disp_rd),
        .disp_old_prd_o (disp_old_prd)
    );

    busy_table u_busy (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .set_valid_i (disp_valid),
        .set_prd_i   (disp_uop.prd),
        .wb_i        (wb),
        .query_a_i   (disp_uop.ps1),
        .query_b_i   (disp_uop.ps2),
        .ready_a_o   (src_a_ready),
        .ready_b_o   (src_b_ready)
    );

    issue_queue #(
        .IQ_DEPTH (IQ_DEPTH)
    ) u_iq (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .disp_valid_i  (disp_valid),
        .disp_uop_i    (disp_uop),
        .src_a_ready_i (src_a_ready),
        .src_b_ready_i (src_b_ready),
        .wb_i          (wb),
        .iq_ready_o    (iq_ready),
        .issue_valid_o (issue_valid),
        .issue_uop_o   (issue_uop)
    );

    // operands are read straight from the issuing entry's tags
    phys_regfile u_prf (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (issue_uop.ps1),
        .raddr_b_i (issue_uop.ps2),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .wb_i      (wb)
    );

    alu_pipe u_alu (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid),
        .issue_uop_i   (issue_uop),
        .rdata_a_i     (rdata_a),
        .rdata_b_i     (rdata_b),
        .wb_o          (wb)
    );

    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .disp_valid_i   (disp_valid),
        .disp_rd_i      (disp_rd),
        .disp_old_prd_i (disp_old_prd),
        .rob_ready_o    (rob_ready),
        .rob_tail_o     (rob_tail),
        .wb_i           (wb),
        .retire_req_o   (retire_req_o),
        .retire_o       (retire_o),
        .retire_ack_i   (retire_ack_i),
        .free_valid_o   (free_valid),
        .free_prd_o     (free_prd)
    );

endmodule

//--- sim/tb_ooo_core.sv
`timescale 1ns/10ps

module tb_ooo_core
    import ooo_pkg::*;
();

    localparam int          NUM_PATS     = 44;
    localparam int          FIELDS       = 7;
    localparam int          MEM_AW       = $clog2(NUM_PATS * FIELDS);
    localparam int          RESET_CYCLES = 8;
    localparam int          IDLE_CYCLES  = 20;
    localparam int          WATCHDOG     = RESET_CYCLES + NUM_PATS * 60 + IDLE_CYCLES;
    localparam logic [31:0] RAND_SEED    = 32'h88a6d4dc;

    logic        clk;
    logic        rst_n;
    logic        in_req;
    uop_t        in_uop;
    logic        in_ack;
    logic        retire_req;
    retire_t     retire;
    logic        retire_ack;
    logic [31:0] pat_mem [NUM_PATS * FIELDS];
    int          tests;
    int          failed_tests;
    int          errors;
    int          retired = 0;
    int          stall_cycles;

    ooo_core #(
        .IQ_DEPTH  (8),
        .ROB_DEPTH (16)
    ) dut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .in_req_i     (in_req),
        .in_uop_i     (in_uop),
        .in_ack_o     (in_ack),
        .retire_req_o (retire_req),
        .retire_o     (retire),
        .retire_ack_i (retire_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("timeout: only %0d of %0d micro-ops retired in time", retired, NUM_PATS);
        $display("FAIL: see errors above");
        $finish;
    end

    // completed retirement handshakes, as the DUT sees them
    always @(posedge clk) begin
        if (rst_n && retire_req && retire_ack) begin
            retired++;
        end
    end

    // seven words per pattern line
    function automatic logic [31:0] pat_field(input int idx, input int col);
        logic [MEM_AW-1:0] addr;
        addr = MEM_AW'(idx * FIELDS + col);
        return pat_mem[addr];
    endfunction

    function automatic int idle_output_errors(input string name);
        int fails;
        fails = 0;
        if (in_ack !== 1'b0) begin
            $display("** Error: %s in_ack_o expected 0 actual %b", name, in_ack);
            fails++;
        end
        if (retire_req !== 1'b0) begin
            $display("** Error: %s retire_req_o expected 0 actual %b", name, retire_req);
            fails++;
        end
        return fails;
    endfunction

    task automatic report(input string name, input int fails);
        tests++;
        errors += fails;
        if (fails == 0) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: FAILED", name);
        end
    endtask

    task automatic send_uop(input int idx);
        logic [31:0] op_field;
        uop_t        uop;
        op_field = pat_field(idx, 0);
        uop.op   = alu_op_e'(op_field[2:0]);
        uop.rd   = areg_t'(pat_field(idx, 1));
        uop.rs1  = areg_t'(pat_field(idx, 2));
        uop.rs2  = areg_t'(pat_field(idx, 3));
        uop.imm  = imm_t'(pat_field(idx, 4));
        in_uop   = uop;
        in_req   = 1'b1;
        @(negedge clk);
        // each extra wait here is a cycle of back-pressure
        while (!in_ack) begin
            stall_cycles++;
            @(negedge clk);
        end
        in_req = 1'b0;
        @(negedge clk);
        while (in_ack) begin
            @(negedge clk);
        end
    endtask

    task automatic take_retirement(input int idx);
        logic [31:0] op_field;
        alu_op_e     op;
        retire_t     expected;
        string       name;
        int          fails;
        int          delay;
        op_field       = pat_field(idx, 0);
        op             = alu_op_e'(op_field[2:0]);
        expected.rd    = areg_t'(pat_field(idx, 5));
        expected.value = pat_field(idx, 6);
        name           = $sformatf("pat_%0d_%s", idx, op.name());
        fails          = 0;
        while (!retire_req) begin
            @(negedge clk);
        end
        if (retire.rd !== expected.rd) begin
            $display("** Error: %s rd expected %0d actual %0d", name, expected.rd, retire.rd);
            fails++;
        end
        if (retire.value !== expected.value) begin
            $display("** Error: %s value expected 0x%08h actual 0x%08h",
                     name, expected.value, retire.value);
            fails++;
        end
        delay = $urandom % 6;
        repeat (delay) @(negedge clk);
        retire_ack = 1'b1;
        @(negedge clk);
        while (retire_req) begin
            @(negedge clk);
        end
        retire_ack = 1'b0;
        report(name, fails);
    endtask

    initial begin
        int fails;
        rst_n        = 1'b0;
        in_req       = 1'b0;
        in_uop       = '0;
        retire_ack   = 1'b0;
        tests        = 0;
        failed_tests = 0;
        errors       = 0;
        stall_cycles = 0;
        void'($urandom(RAND_SEED));
        $readmemh("sim/ooo_patterns.txt", pat_mem);

        fails = 0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            fails += idle_output_errors("reset");
        end
        rst_n = 1'b1;
        @(negedge clk);
        fails += idle_output_errors("reset");
        report("reset", fails);

        fork
            begin
                for (int i = 0; i < NUM_PATS; i++) begin
                    send_uop(i);
                end
            end
            begin
                for (int i = 0; i < NUM_PATS; i++) begin
                    take_retirement(i);
                end
            end
        join

        fails = 0;
        if (stall_cycles == 0) begin
            $display("input was never stalled, so back-pressure was not exercised");
            fails++;
        end
        // nothing may retire twice
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            if (retire_req) begin
                $display("retire_req_o rose again after the last micro-op had retired");
                fails++;
            end
        end
        if (retired != NUM_PATS) begin
            $display("** Error: retire_count expected %0d actual %0d", NUM_PATS, retired);
            fails++;
        end
        report("backpressure", fails);

        $display("tests run: %0d, failed: %0d, check errors: %0d, stall cycles: %0d",
                 tests, failed_tests, errors, stall_cycles);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- sim/ooo_patterns.txt
// op rd rs1 rs2 imm | exp_rd exp_value, all hex, op 0..7 = add sub and or xor slt sll li
// expected values assume all 32 registers start at zero
7 01 00 00 0005 01 00000005
7 02 00 00 fffd 02 fffffffd
0 03 01 02 0000 03 00000002
1 04 03 01 0000 04 fffffffd
2 05 04 01 0000 05 00000005
3 06 05 02 0000 06 fffffffd
4 07 06 01 0000 07 fffffff8
5 08 02 01 0000 08 00000001
5 09 01 02 0000 09 00000000
6 0a 01 03 0000 0a 00000014
7 0b 00 00 7fff 0b 00007fff
6 0c 0b 01 0000 0c 000fffe0
7 0d 00 00 0024 0d 00000024
6 0e 01 0d 0000 0e 00000050
0 00 00 01 0000 00 00000005
0 00 00 00 0000 00 0000000a
1 0f 00 0c 0000 0f fff0002a
5 10 0f 00 0000 10 00000001
4 01 01 01 0000 01 00000000
0 01 01 02 0000 01 fffffffd
7 14 00 00 0001 14 00000001
0 14 14 14 0000 14 00000002
0 14 14 14 0000 14 00000004
0 14 14 14 0000 14 00000008
0 14 14 14 0000 14 00000010
0 14 14 14 0000 14 00000020
1 15 14 03 0000 15 0000001e
3 16 15 0a 0000 16 0000001e
2 17 16 07 0000 17 00000018
4 14 14 17 0000 14 00000038
7 18 00 00 8000 18 ffff8000
5 19 18 0b 0000 19 00000001
6 18 18 19 0000 18 ffff0000
0 1a 18 0b 0000 1a ffff7fff
1 1a 1a 1a 0000 1a 00000000
5 1b 1a 1a 0000 1b 00000000
0 14 14 14 0000 14 00000070
0 14 14 01 0000 14 0000006d
7 02 00 00 1234 02 00001234
0 03 02 02 0000 03 00002468
4 04 03 02 0000 04 0000365c
1 05 04 03 0000 05 000011f4
3 1f 05 00 0000 1f 000011fe
6 1e 1f 09 0000 1e 000011fe

//--- compile.f
rtl/ooo_pkg.sv
rtl/rename_unit.sv
rtl/busy_table.sv
rtl/issue_queue.sv
rtl/phys_regfile.sv
rtl/alu_pipe.sv
rtl/reorder_buffer.sv
rtl/ooo_core.sv
sim/tb_ooo_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_ooo_core
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
